// ==== src/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int REG_NUM    = 32;
  localparam int SHAMT_W    = 5;   // Shift amount field

  localparam logic [XLEN-1:0] INST_STEP = 32'd4;

  // funct3 of OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 of BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } branch_e;

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_BUSY,
    HS_ACK
  } hs_state_e;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  logic [rv_pkg::XLEN-1:0]       inst_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  input  logic                          ex_valid_i,
  input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
  output logic                          ack_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  output logic                          dec_valid_o,
  output rv_pkg::alu_op_e               alu_op_o,
  output rv_pkg::branch_e               branch_kind_o,
  output logic [rv_pkg::XLEN-1:0]       op_a_o,
  output logic [rv_pkg::XLEN-1:0]       op_b_o,
  output logic [rv_pkg::XLEN-1:0]       rs1_val_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_val_o,
  output logic [rv_pkg::XLEN-1:0]       imm_o,
  output logic [rv_pkg::XLEN-1:0]       pc_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
  output logic                          wb_en_o
);

  rv_pkg::hs_state_e        state;
  rv_pkg::opcode_e          opcode;
  logic [2:0]               funct3;
  logic                     accept;
  logic [rv_pkg::XLEN-1:0]  imm_i_type;
  logic [rv_pkg::XLEN-1:0]  imm_u_type;
  logic [rv_pkg::XLEN-1:0]  imm_j_type;
  logic [rv_pkg::XLEN-1:0]  imm_b_type;
  rv_pkg::alu_op_e          alu_op_d;
  rv_pkg::branch_e          branch_d;
  logic [rv_pkg::XLEN-1:0]  op_a_d;
  logic [rv_pkg::XLEN-1:0]  op_b_d;
  logic [rv_pkg::XLEN-1:0]  imm_d;
  logic                     wb_en_d;

  // alt selects SUB or SRA
  function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_pkg::F3_ADD:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:  return rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  return rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: return rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  return rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   return rv_pkg::ALU_OR;
      default:         return rv_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode     = rv_pkg::opcode_e'(inst_i[6:0]);
  assign funct3     = inst_i[14:12];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];
  assign accept     = (state == rv_pkg::HS_IDLE) && req_i;

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    alu_op_d = rv_pkg::ALU_ADD;  // Unknown opcode runs as NOP
    branch_d = rv_pkg::BR_NONE;
    op_a_d   = rs1_data_i;
    op_b_d   = rs2_data_i;
    imm_d    = '0;
    wb_en_d  = 1'b0;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        op_a_d  = '0;
        op_b_d  = imm_u_type;
        imm_d   = imm_u_type;
        wb_en_d = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        op_a_d  = pc_i;
        op_b_d  = imm_u_type;
        imm_d   = imm_u_type;
        wb_en_d = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        branch_d = rv_pkg::BR_JAL;
        imm_d    = imm_j_type;
        wb_en_d  = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        branch_d = rv_pkg::BR_JALR;
        op_b_d   = imm_i_type;
        imm_d    = imm_i_type;
        wb_en_d  = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        imm_d = imm_b_type;
        case (funct3)
          rv_pkg::F3_BEQ:  branch_d = rv_pkg::BR_BEQ;
          rv_pkg::F3_BNE:  branch_d = rv_pkg::BR_BNE;
          rv_pkg::F3_BLT:  branch_d = rv_pkg::BR_BLT;
          rv_pkg::F3_BGE:  branch_d = rv_pkg::BR_BGE;
          rv_pkg::F3_BLTU: branch_d = rv_pkg::BR_BLTU;
          rv_pkg::F3_BGEU: branch_d = rv_pkg::BR_BGEU;
          default:         branch_d = rv_pkg::BR_NONE;
        endcase
      end
      rv_pkg::OPC_OP_IMM: begin
        alu_op_d = alu_decode(funct3, (funct3 == rv_pkg::F3_SR) && inst_i[30]);
        op_b_d   = imm_i_type;
        imm_d    = imm_i_type;
        wb_en_d  = 1'b1;
      end
      rv_pkg::OPC_OP: begin
        alu_op_d = alu_decode(funct3, inst_i[30]);
        wb_en_d  = 1'b1;
      end
      default: ;
    endcase
  end

  // Decoded fields, captured once per request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      alu_op_o      <= alu_op_d;
      branch_kind_o <= branch_d;
      op_a_o        <= op_a_d;
      op_b_o        <= op_b_d;
      rs1_val_o     <= rs1_data_i;
      rs2_val_o     <= rs2_data_i;
      imm_o         <= imm_d;
      pc_o          <= pc_i;
      rd_o          <= inst_i[11:7];
      wb_en_o       <= wb_en_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state       <= rv_pkg::HS_IDLE;
      ack_o       <= 1'b0;
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= accept;
      case (state)
        rv_pkg::HS_IDLE: if (req_i) state <= rv_pkg::HS_BUSY;
        rv_pkg::HS_BUSY: begin
          if (ex_valid_i) begin  // Result lands this edge
            state <= rv_pkg::HS_ACK;
            ack_o <= 1'b1;
          end
        end
        rv_pkg::HS_ACK: begin
          if (!req_i) begin
            state <= rv_pkg::HS_IDLE;
            ack_o <= 1'b0;
          end
        end
        default: state <= rv_pkg::HS_IDLE;
      endcase
    end
  end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          dec_valid_i,
  input  rv_pkg::alu_op_e               alu_op_i,
  input  rv_pkg::branch_e               branch_kind_i,
  input  logic [rv_pkg::XLEN-1:0]       op_a_i,
  input  logic [rv_pkg::XLEN-1:0]       op_b_i,
  input  logic [rv_pkg::XLEN-1:0]       rs1_val_i,
  input  logic [rv_pkg::XLEN-1:0]       rs2_val_i,
  input  logic [rv_pkg::XLEN-1:0]       imm_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                          wb_en_i,
  output logic                          ex_valid_o,
  output logic [rv_pkg::XLEN-1:0]       ex_result_o,
  output logic [rv_pkg::XLEN-1:0]       ex_next_pc_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic                          ex_wb_en_o
);

  logic [rv_pkg::SHAMT_W-1:0] shamt;
  logic [rv_pkg::XLEN-1:0]    alu_res;
  logic [rv_pkg::XLEN-1:0]    link_addr;
  logic [rv_pkg::XLEN-1:0]    next_pc;
  logic                       taken;
  logic                       lt_s;
  logic                       lt_u;

  assign shamt     = op_b_i[rv_pkg::SHAMT_W-1:0];
  assign link_addr = pc_i + rv_pkg::INST_STEP;
  assign lt_s      = $signed(rs1_val_i) < $signed(rs2_val_i);
  assign lt_u      = rs1_val_i < rs2_val_i;

  always_comb begin
    case (alu_op_i)
      rv_pkg::ALU_SUB:  alu_res = op_a_i - op_b_i;
      rv_pkg::ALU_SLL:  alu_res = op_a_i << shamt;
      rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a_i) < $signed(op_b_i)};
      rv_pkg::ALU_SLTU: alu_res = {31'b0, op_a_i < op_b_i};
      rv_pkg::ALU_XOR:  alu_res = op_a_i ^ op_b_i;
      rv_pkg::ALU_SRL:  alu_res = op_a_i >> shamt;
      rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a_i) >>> shamt);
      rv_pkg::ALU_OR:   alu_res = op_a_i | op_b_i;
      rv_pkg::ALU_AND:  alu_res = op_a_i & op_b_i;
      default:          alu_res = op_a_i + op_b_i;
    endcase
  end

  always_comb begin
    case (branch_kind_i)
      rv_pkg::BR_BEQ:  taken = (rs1_val_i == rs2_val_i);
      rv_pkg::BR_BNE:  taken = (rs1_val_i != rs2_val_i);
      rv_pkg::BR_BLT:  taken = lt_s;
      rv_pkg::BR_BGE:  taken = !lt_s;
      rv_pkg::BR_BLTU: taken = lt_u;
      rv_pkg::BR_BGEU: taken = !lt_u;
      default:         taken = 1'b0;
    endcase
    if (branch_kind_i == rv_pkg::BR_JALR)
      next_pc = rs1_val_i + imm_i;  // Bit 0 kept as is
    else if (taken || branch_kind_i == rv_pkg::BR_JAL)
      next_pc = pc_i + imm_i;
    else
      next_pc = link_addr;
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      ex_result_o  <= (branch_kind_i == rv_pkg::BR_JAL || branch_kind_i == rv_pkg::BR_JALR) ?
                      link_addr : alu_res;
      ex_next_pc_o <= next_pc;
      ex_rd_o      <= rd_i;
      ex_wb_en_o   <= wb_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) ex_valid_o <= 1'b0;
    else          ex_valid_o <= dec_valid_i;
  end

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ps

module rv_result (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          ex_valid_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_result_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_next_pc_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic                          ex_wb_en_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
  output logic [rv_pkg::XLEN-1:0]       result_o,
  output logic [rv_pkg::XLEN-1:0]       next_pc_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::REG_NUM];
  logic                    wr_en;

  // x0 is never written
  assign wr_en = ex_valid_i && ex_wb_en_i && (ex_rd_i != '0);

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < rv_pkg::REG_NUM; i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[ex_rd_i] <= ex_result_i;
    end
  end

  // Held until the next instruction completes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_o  <= '0;
      next_pc_o <= '0;
      wb_rd_o   <= '0;
    end else if (ex_valid_i) begin
      result_o  <= wr_en ? ex_result_i : '0;
      next_pc_o <= ex_next_pc_i;
      wb_rd_o   <= wr_en ? ex_rd_i : '0;
    end
  end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  logic [rv_pkg::XLEN-1:0]       inst_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  output logic                          ack_o,
  output logic [rv_pkg::XLEN-1:0]       result_o,
  output logic [rv_pkg::XLEN-1:0]       next_pc_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o
);

  logic                          dec_valid;
  rv_pkg::alu_op_e               alu_op;
  rv_pkg::branch_e               branch_kind;
  logic [rv_pkg::XLEN-1:0]       op_a;
  logic [rv_pkg::XLEN-1:0]       op_b;
  logic [rv_pkg::XLEN-1:0]       rs1_val;
  logic [rv_pkg::XLEN-1:0]       rs2_val;
  logic [rv_pkg::XLEN-1:0]       imm;
  logic [rv_pkg::XLEN-1:0]       pc;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic                          wb_en;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;
  logic                          ex_valid;   // Also closes the handshake
  logic [rv_pkg::XLEN-1:0]       ex_result;
  logic [rv_pkg::XLEN-1:0]       ex_next_pc;
  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd;
  logic                          ex_wb_en;

  rv_decode u_decode (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .ex_valid_i    (ex_valid),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .ack_o         (ack_o),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .dec_valid_o   (dec_valid),
    .alu_op_o      (alu_op),
    .branch_kind_o (branch_kind),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .rs1_val_o     (rs1_val),
    .rs2_val_o     (rs2_val),
    .imm_o         (imm),
    .pc_o          (pc),
    .rd_o          (rd),
    .wb_en_o       (wb_en)
  );

  rv_execute u_execute (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .dec_valid_i   (dec_valid),
    .alu_op_i      (alu_op),
    .branch_kind_i (branch_kind),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .rs1_val_i     (rs1_val),
    .rs2_val_i     (rs2_val),
    .imm_i         (imm),
    .pc_i          (pc),
    .rd_i          (rd),
    .wb_en_i       (wb_en),
    .ex_valid_o    (ex_valid),
    .ex_result_o   (ex_result),
    .ex_next_pc_o  (ex_next_pc),
    .ex_rd_o       (ex_rd),
    .ex_wb_en_o    (ex_wb_en)
  );

  rv_result u_result (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ex_valid_i    (ex_valid),
    .ex_result_i   (ex_result),
    .ex_next_pc_i  (ex_next_pc),
    .ex_rd_i       (ex_rd),
    .ex_wb_en_i    (ex_wb_en),
    .rs1_addr_i    (rs1_addr),
    .rs2_addr_i    (rs2_addr),
    .rs1_data_o    (rs1_data),
    .rs2_data_o    (rs2_data),
    .result_o      (result_o),
    .next_pc_o     (next_pc_o),
    .wb_rd_o       (wb_rd_o)
  );

endmodule

// ==== verif/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              req_i,
  input logic              ack_o,
  input rv_pkg::hs_state_e state_i
);

  int fail_cnt = 0;  // Assertion failures

  // No ack without a request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!ack_o && !req_i) |=> !ack_o)
    else begin
      fail_cnt++;
      $error("ack_o rose while req_i was low");
    end

  ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_o && req_i) |=> ack_o)
    else begin
      fail_cnt++;
      $error("ack_o dropped while req_i was still high");
    end

  // Release takes exactly one edge
  ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_i == rv_pkg::HS_ACK && !req_i) |=> !ack_o)
    else begin
      fail_cnt++;
      $error("ack_o still high one cycle after req_i fell");
    end

endmodule

bind rv_core rv_core_assert u_assert (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .ack_o   (ack_o),
  .state_i (u_decode.state)
);

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int ACK_EDGES    = 3;   // E0 samples req, ack set at E2
  localparam int ACK_LIMIT    = 20;
  localparam int N_IMM        = 32;
  localparam int N_REG        = 32;
  localparam int N_UPPER      = 8;
  localparam int N_BRANCH     = 20;  // Two operand setups plus 6 x 3 branches
  localparam int N_JUMP       = 8;
  localparam int N_X0         = 2;
  localparam int N_INST       = N_IMM + N_REG + N_UPPER + N_BRANCH + N_JUMP + N_X0;
  localparam int TIMEOUT_NS   = (N_INST * 10 + RESET_CYCLES) * CLK_PERIOD;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_i;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        ack_o;
  logic [31:0] result_o;
  logic [31:0] next_pc_o;
  logic [4:0]  wb_rd_o;

  logic [31:0] ref_regs [32];
  logic [31:0] lfsr_state;
  logic [31:0] pc_cur;
  logic        ack_seen = 1'b0;
  int          errors = 0;
  int          checks = 0;
  string       name_q [$];
  logic [31:0] res_q [$];
  logic [31:0] npc_q [$];
  logic [4:0]  rd_q [$];

  rv_core UUT (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .inst_i    (inst_i),
    .pc_i      (pc_i),
    .ack_o     (ack_o),
    .result_o  (result_o),
    .next_pc_o (next_pc_o),
    .wb_rd_o   (wb_rd_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Taps 32, 22, 2, 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm,
                                        input rv_pkg::opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Expected outcome of one instruction against ref_regs
  function automatic void ref_exec(input logic [31:0] inst, input logic [31:0] pc,
                                   output logic [31:0] res, output logic [4:0] rd,
                                   output logic [31:0] npc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    a     = ref_regs[inst[19:15]];
    b     = ref_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'h000};
    res   = '0;
    rd    = inst[11:7];
    npc   = pc + 32'd4;
    case (inst[6:0])
      rv_pkg::OPC_OP_IMM: res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
      rv_pkg::OPC_OP:     res = alu_ref(inst[14:12], inst[30], a, b);
      rv_pkg::OPC_LUI:    res = imm_u;
      rv_pkg::OPC_AUIPC:  res = pc + imm_u;
      rv_pkg::OPC_JAL: begin
        res = pc + 32'd4;
        npc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      rv_pkg::OPC_JALR: begin
        res = pc + 32'd4;
        npc = a + imm_i;
      end
      rv_pkg::OPC_BRANCH: begin
        rd = '0;
        if (taken_ref(inst[14:12], a, b))
          npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      default: rd = '0;
    endcase
    if (rd == '0) res = '0;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // One full four-phase transaction, called on a falling edge
  task automatic run_inst(input string name, input logic [31:0] inst, input int hold);
    logic [31:0] exp_res;
    logic [31:0] exp_npc;
    logic [31:0] held_res;
    logic [31:0] held_npc;
    logic [4:0]  held_rd;
    logic [4:0]  exp_rd;
    int          waited;
    ref_exec(inst, pc_cur, exp_res, exp_rd, exp_npc);
    if (exp_rd != '0) ref_regs[exp_rd] = exp_res;
    name_q.push_back(name);
    res_q.push_back(exp_res);
    npc_q.push_back(exp_npc);
    rd_q.push_back(exp_rd);
    inst_i = inst;
    pc_i   = pc_cur;
    req_i  = 1'b1;
    waited = 0;
    while (ack_o !== 1'b1 && waited < ACK_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (ack_o !== 1'b1) begin
      errors++;
      $display("No ack from the DUT within %0d cycles for %s", ACK_LIMIT, name);
    end else begin
      compare({name, " ack latency"}, ACK_EDGES, waited);
    end
    held_res = result_o;
    held_npc = next_pc_o;
    held_rd  = wb_rd_o;
    repeat (hold) begin
      @(negedge clk_i);
      compare({name, " ack held"}, 32'd1, ack_o);
      compare({name, " result held"}, held_res, result_o);
      compare({name, " next_pc held"}, held_npc, next_pc_o);
      compare({name, " wb_rd held"}, held_rd, wb_rd_o);
    end
    req_i  = 1'b0;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (ack_o !== 1'b0 && waited < ACK_LIMIT);
    compare({name, " ack release"}, 32'd1, waited);
    pc_cur = pc_cur + 32'd4;
  endtask

  task automatic report_test(input string name, input int first_err, input int n_inst);
    $display("test %-9s %0d instructions, %0d errors", name, n_inst, errors - first_err);
  endtask

  // Checks outputs on every rising ack
  always @(negedge clk_i) begin
    string nm;
    if (ack_o === 1'b1 && ack_seen !== 1'b1) begin
      if (name_q.size() == 0) begin
        errors++;
        $display("The DUT raised ack with no instruction pending");
      end else begin
        nm = name_q.pop_front();
        compare({nm, " result"}, res_q.pop_front(), result_o);
        compare({nm, " next_pc"}, npc_q.pop_front(), next_pc_o);
        compare({nm, " wb_rd"}, rd_q.pop_front(), wb_rd_o);
      end
    end
    ack_seen = ack_o;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] r_d;
    logic [31:0] r_s1;
    logic [31:0] r_s2;
    logic [31:0] imm;
    logic [2:0]  f3;
    int          first;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    inst_i     = '0;
    pc_i       = '0;
    pc_cur     = 32'h0000_1000;
    lfsr_state = 32'd50;
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    first = errors;
    for (int i = 0; i < N_IMM; i++) begin
      take_bits(5, r_d);
      take_bits(5, r_s1);
      take_bits(12, imm);
      f3 = i[2:0];
      if (f3 == 3'd1) imm[11:5] = 7'h00;
      if (f3 == 3'd5) imm[11:5] = i[3] ? 7'h20 : 7'h00;  // SRAI or SRLI
      run_inst("alu_imm", enc_i(f3, r_d[4:0], r_s1[4:0], imm[11:0], rv_pkg::OPC_OP_IMM), 0);
    end
    report_test("alu_imm", first, N_IMM);

    first = errors;
    for (int i = 0; i < N_REG; i++) begin
      take_bits(5, r_d);
      take_bits(5, r_s1);
      take_bits(5, r_s2);
      f3 = i[2:0];
      run_inst("alu_reg", enc_r((i[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                f3, r_d[4:0], r_s1[4:0], r_s2[4:0]), 0);
    end
    report_test("alu_reg", first, N_REG);

    first = errors;
    for (int i = 0; i < N_UPPER; i++) begin
      take_bits(5, r_d);
      take_bits(20, imm);
      if (i[0]) run_inst("upper", {imm[19:0], r_d[4:0], rv_pkg::OPC_AUIPC}, 0);
      else      run_inst("upper", {imm[19:0], r_d[4:0], rv_pkg::OPC_LUI}, 0);
    end
    report_test("upper", first, N_UPPER);

    first = errors;
    run_inst("branch", enc_i(3'd0, 5'd1, 5'd0, 12'hFFB, rv_pkg::OPC_OP_IMM), 0);  // x1 = -5
    run_inst("branch", enc_i(3'd0, 5'd2, 5'd0, 12'h007, rv_pkg::OPC_OP_IMM), 0);  // x2 = 7
    for (int b = 0; b < 8; b++) begin
      if (b == 2 || b == 3) continue;  // No branch on these funct3 codes
      for (int p = 0; p < 3; p++) begin
        take_bits(12, imm);
        run_inst("branch", enc_b(b[2:0], (p == 1) ? 5'd2 : 5'd1, (p == 0) ? 5'd2 : 5'd1,
                                 {imm[11:0], 1'b0}), 0);
      end
    end
    report_test("branch", first, N_BRANCH);

    first = errors;
    for (int i = 0; i < N_JUMP; i++) begin
      take_bits(5, r_d);
      take_bits(5, r_s1);
      take_bits(20, imm);
      if (i[0])
        run_inst("jump", enc_i(3'd0, r_d[4:0], r_s1[4:0], imm[11:0], rv_pkg::OPC_JALR), 0);
      else
        run_inst("jump", {imm[19], imm[9:0], imm[10], imm[18:11], r_d[4:0],
                          rv_pkg::OPC_JAL}, 0);
    end
    report_test("jump", first, N_JUMP);

    // x0 write then read back, with req held past ack
    first = errors;
    run_inst("x0_hold", enc_i(3'd0, 5'd0, 5'd5, 12'h123, rv_pkg::OPC_OP_IMM), 4);
    run_inst("x0_hold", enc_i(3'd0, 5'd9, 5'd0, 12'h7FF, rv_pkg::OPC_OP_IMM), 4);
    report_test("x0_hold", first, N_X0);

    if (UUT.u_assert.fail_cnt != 0) begin
      errors = errors + UUT.u_assert.fail_cnt;
      $display("Handshake assertions failed %0d times", UUT.u_assert.fail_cnt);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
src/rv_pkg.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_decode.sv
  - src/rv_execute.sv
  - src/rv_result.sv
  - src/rv_core.sv
  - target: test
    files:
      - verif/rv_core_assert.sv
      - verif/rv_core_tb.sv
